// ==== Makefile ====
SIM        ?= verilator
TOP        ?= xnorLayerTb
DUT_TOP    ?= xnorLayerTop
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	rm -f $(LOG)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q 'All tests passed!' $(LOG); then \
		echo "simulation PASSED"; \
	else \
		echo "simulation FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
logic/layerPkg.sv
logic/apbPkg.sv
logic/rowAccum.sv
logic/scanSequencer.sv
logic/sparseXnorArray.sv
logic/apbRegs.sv
logic/xnorLayerTop.sv
dv/tbClock.sv
dv/xnorLayerTb.sv

// ==== dv/tbClock.sv ====
`timescale 1ns/1ns

module tbClock #(
  parameter int HalfPeriod = 4,
  parameter int ResetCycles = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #HalfPeriod clk = ~clk;
  end

  // release just after an edge so the first transfer starts clean
  initial begin
    rst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

// ==== dv/xnorLayerTb.sv ====
`timescale 1ns/1ns

module xnorLayerTb;

  localparam int Inputs = 8;
  localparam int Rows = 4;
  localparam int MaxLen = 5;
  localparam int Nnz = 10;
  // compressed rows {1,4,6} {} {0,2,3,5,7} {6,0} with entry 0 in the low byte
  localparam logic [(Rows+1)*8-1:0] RowStart = {8'd10, 8'd8, 8'd3, 8'd3, 8'd0};
  localparam logic [Rows*8-1:0] RowLen = {8'd2, 8'd5, 8'd0, 8'd3};
  localparam logic [Nnz*8-1:0] ColIdx = {8'd0, 8'd6, 8'd7, 8'd5, 8'd3,
                                         8'd2, 8'd0, 8'd6, 8'd4, 8'd1};
  localparam logic [Nnz-1:0] Signs = 10'b10_0110_1101;
  localparam int RandomRuns = 32;
  localparam int PollLimit = 4 * Inputs;
  localparam int TimeoutCycles = 40 * (Inputs + 10) + 200;

  logic clk;
  logic rst;
  logic PSEL;
  logic PENABLE;
  logic PWRITE;
  apbPkg::addr_t PADDR;
  apbPkg::data_t PWDATA;
  apbPkg::data_t PRDATA;
  logic PREADY;
  logic PSLVERR;

  int errCount = 0;
  int checkCount = 0;
  int cycleCount = 0;
  logic [31:0] lcgState;
  logic [Inputs-1:0] lastVec;
  apbPkg::data_t rdData;

  tbClock i_tbClock (
    .clk(clk),
    .rst(rst)
  );

  xnorLayerTop #(
    .Inputs(Inputs),
    .Rows(Rows),
    .RowStart(RowStart),
    .RowLen(RowLen),
    .ColIdx(ColIdx),
    .Signs(Signs),
    .MaxLen(MaxLen)
  ) i_xnorLayerTop (
    .clk(clk),
    .rst(rst),
    .PSEL(PSEL),
    .PENABLE(PENABLE),
    .PWRITE(PWRITE),
    .PADDR(PADDR),
    .PWDATA(PWDATA),
    .PRDATA(PRDATA),
    .PREADY(PREADY),
    .PSLVERR(PSLVERR)
  );

  function automatic logic isResultAddr(input apbPkg::addr_t a);
    int off;
    off = int'(a) - int'(apbPkg::ResultBase);
    return (off >= 0) && (off % 4 == 0) && (off / 4 < Rows);
  endfunction

  function automatic logic isMapped(input apbPkg::addr_t a);
    return (a == apbPkg::CtrlAddr) || (a == apbPkg::StatusAddr) ||
           (a == apbPkg::InputAddr) || isResultAddr(a);
  endfunction

  function automatic apbPkg::addr_t resultAddr(input int row);
    return apbPkg::addr_t'(int'(apbPkg::ResultBase) + 4 * row);
  endfunction

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // score starts at the normalising length and moves one step per used column
  function automatic apbPkg::data_t expectedSum(input int row, input logic [Inputs-1:0] vec);
    int first;
    int len;
    int col;
    int score;
    first = int'(RowStart[row*8 +: 8]);
    len = int'(RowLen[row*8 +: 8]);
    score = MaxLen;
    for (int k = first; k < first + len; k++) begin
      col = int'(ColIdx[k*8 +: 8]);
      if (vec[col] == Signs[k]) begin
        score++;
      end else begin
        score--;
      end
    end
    return apbPkg::data_t'(score);
  endfunction

  task automatic noteFailure(input string what);
    errCount++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic checkValue(input string name, input apbPkg::data_t expected,
                            input apbPkg::data_t actual);
    checkCount++;
    assert (actual === expected) else begin
      errCount++;
      $display("MISMATCH at %0t: %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
    end
  endtask

  // no wait states on this slave
  pReadyHigh: assert property (@(posedge clk) disable iff (rst) PREADY)
    else noteFailure("PREADY was low");

  pErrOnlyInAccess: assert property (@(posedge clk) disable iff (rst)
    PSLVERR |-> (PSEL && PENABLE))
    else noteFailure("PSLVERR raised outside an access cycle");

  pErrUnmapped: assert property (@(posedge clk) disable iff (rst)
    (PSEL && PENABLE && !isMapped(PADDR)) |-> PSLVERR)
    else noteFailure("access to an unmapped address was not refused");

  pErrReadOnly: assert property (@(posedge clk) disable iff (rst)
    (PSEL && PENABLE && PWRITE && (PADDR == apbPkg::StatusAddr || isResultAddr(PADDR)))
    |-> PSLVERR)
    else noteFailure("write to a read-only register was not refused");

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      $display("timeout: run still going after %0d cycles", cycleCount);
      $display("Test failures found");
      $finish;
    end
  end

  // entered 1 ns after a rising edge and left 1 ns after the access edge
  task automatic writeReg(input apbPkg::addr_t addr, input apbPkg::data_t data,
                          input logic expErr);
    PSEL = 1'b1;
    PENABLE = 1'b0;
    PWRITE = 1'b1;
    PADDR = addr;
    PWDATA = data;
    @(posedge clk);
    #1;
    PENABLE = 1'b1;
    @(negedge clk);
    checkValue($sformatf("PSLVERR write 0x%02h", addr), apbPkg::data_t'(expErr),
               apbPkg::data_t'(PSLVERR));
    @(posedge clk);
    #1;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
  endtask

  task automatic readReg(input apbPkg::addr_t addr, output apbPkg::data_t data,
                         input logic expErr);
    PSEL = 1'b1;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = addr;
    @(posedge clk);
    #1;
    PENABLE = 1'b1;
    @(negedge clk);
    data = PRDATA;
    checkValue($sformatf("PSLVERR read 0x%02h", addr), apbPkg::data_t'(expErr),
               apbPkg::data_t'(PSLVERR));
    @(posedge clk);
    #1;
    PSEL = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic checkResults(input logic [Inputs-1:0] vec);
    apbPkg::data_t got;
    for (int r = 0; r < Rows; r++) begin
      readReg(resultAddr(r), got, 1'b0);
      checkValue($sformatf("RESULT[%0d]", r), expectedSum(r, vec), got);
    end
  endtask

  task automatic runVector(input logic [Inputs-1:0] vec, input logic probeBusy);
    apbPkg::data_t status;
    logic sawBusy;
    logic sawDone;
    int polls;
    writeReg(apbPkg::InputAddr, apbPkg::data_t'(vec), 1'b0);
    writeReg(apbPkg::CtrlAddr, 32'h1, 1'b0);
    if (probeBusy) begin
      // both of these must bounce while the scan is in flight
      writeReg(apbPkg::InputAddr, ~apbPkg::data_t'(vec), 1'b1);
      writeReg(apbPkg::CtrlAddr, 32'h1, 1'b1);
    end
    sawBusy = 1'b0;
    sawDone = 1'b0;
    polls = 0;
    while (!sawDone && polls < PollLimit) begin
      readReg(apbPkg::StatusAddr, status, 1'b0);
      // done from the previous run must already be gone
      if (polls == 0) begin
        checkValue("STATUS after start", 32'h1, status);
      end
      sawBusy = sawBusy | status[0];
      sawDone = status[1];
      polls++;
    end
    if (!sawDone) begin
      noteFailure("run never reported done");
    end
    if (!sawBusy) begin
      noteFailure("busy never seen before done");
    end
    checkValue("STATUS at done", 32'h2, status);
    if (probeBusy) begin
      readReg(apbPkg::InputAddr, status, 1'b0);
      checkValue("INPUT after refused write", apbPkg::data_t'(vec), status);
    end
    checkResults(vec);
    lastVec = vec;
  endtask

  initial begin
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = '0;
    PWDATA = '0;
    lcgState = 32'ha11dec46;
    lastVec = '0;
    @(negedge rst);
    @(posedge clk);
    #1;

    // everything reads zero out of reset
    readReg(apbPkg::StatusAddr, rdData, 1'b0);
    checkValue("STATUS after reset", 32'h0, rdData);
    for (int r = 0; r < Rows; r++) begin
      readReg(resultAddr(r), rdData, 1'b0);
      checkValue($sformatf("RESULT[%0d] after reset", r), 32'h0, rdData);
    end

    runVector('0, 1'b0);
    runVector('1, 1'b1);

    for (int n = 0; n < RandomRuns; n++) begin
      lcgState = lcgNext(lcgState);
      runVector(lcgState[23:16], 1'b0);
    end

    // refused accesses while idle
    writeReg(apbPkg::StatusAddr, 32'h3, 1'b1);
    writeReg(resultAddr(0), 32'h3f, 1'b1);
    writeReg(resultAddr(Rows - 1), 32'h15, 1'b1);
    writeReg(resultAddr(Rows), 32'h1, 1'b1);
    writeReg(8'h0c, 32'hff, 1'b1);
    writeReg(8'h11, 32'h1, 1'b1);
    readReg(8'h0c, rdData, 1'b1);
    readReg(8'h40, rdData, 1'b1);

    // state still that of the last completed run
    readReg(apbPkg::StatusAddr, rdData, 1'b0);
    checkValue("STATUS after refused writes", 32'h2, rdData);
    readReg(apbPkg::InputAddr, rdData, 1'b0);
    checkValue("INPUT after refused writes", apbPkg::data_t'(lastVec), rdData);
    checkResults(lastVec);

    $display("checks: %0d, errors: %0d, cycles: %0d", checkCount, errCount, cycleCount);
    if (errCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== logic/apbPkg.sv ====
package apbPkg;

  localparam int AddrW = 8;
  localparam int DataW = 32;

  // byte address and data word of the APB slave
  typedef logic [AddrW-1:0] addr_t;
  typedef logic [DataW-1:0] data_t;

  // register map
  // bit 0 starts a run, reads back as zero
  localparam addr_t CtrlAddr = 8'h00;

  // bit 0 busy, bit 1 sticky done
  localparam addr_t StatusAddr = 8'h04;

  // low Inputs bits hold the activation vector
  localparam addr_t InputAddr = 8'h08;

  // row j result lives at ResultBase + 4*j
  localparam addr_t ResultBase = 8'h10;

endpackage

// ==== logic/apbRegs.sv ====
`timescale 1ns/1ns

module apbRegs #(
  parameter int Inputs = 8,
  parameter int Rows = 1
) (
  input  logic clk,
  input  logic rst,
  input  logic PSEL,
  input  logic PENABLE,
  input  logic PWRITE,
  input  apbPkg::addr_t PADDR,
  input  apbPkg::data_t PWDATA,
  output apbPkg::data_t PRDATA,
  output logic PREADY,
  output logic PSLVERR,
  output logic start,
  output logic [Inputs-1:0] inVec,
  input  logic busy,
  input  logic done,
  input  logic [Rows*$bits(layerPkg::sum_t)-1:0] sums
);

  localparam int SumW = $bits(layerPkg::sum_t);
  localparam int RowW = (Rows > 1) ? $clog2(Rows) : 1;

  logic access;
  logic isCtrl;
  logic isStatus;
  logic isInput;
  logic isResult;
  logic slvErr;
  logic wrOk;
  logic startWrite;
  apbPkg::addr_t resOffset;
  logic [RowW-1:0] resIdx;

  logic [Inputs-1:0] inVecReg;
  logic doneFlag;
  logic startReg;
  layerPkg::sum_t results [Rows];

  // address decode
  assign access = PSEL & PENABLE;
  assign isCtrl = (PADDR == apbPkg::CtrlAddr);
  assign isStatus = (PADDR == apbPkg::StatusAddr);
  assign isInput = (PADDR == apbPkg::InputAddr);
  assign resOffset = PADDR - apbPkg::ResultBase;
  assign resIdx = resOffset[RowW+1:2];
  assign isResult = (PADDR >= apbPkg::ResultBase) && (resOffset[1:0] == 2'b00) &&
                    (int'(resOffset[7:2]) < Rows);

  // unmapped, read-only, or ctrl/input touched mid-run
  assign slvErr = access & (~(isCtrl | isStatus | isInput | isResult) |
                            (PWRITE & (isStatus | isResult)) |
                            (PWRITE & busy & (isCtrl | isInput)));

  assign wrOk = access & PWRITE & ~slvErr;
  assign startWrite = wrOk & isCtrl & PWDATA[0];

  assign PREADY = 1'b1;
  assign PSLVERR = slvErr;
  assign start = startReg;
  assign inVec = inVecReg;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      inVecReg <= '0;
      doneFlag <= 1'b0;
      startReg <= 1'b0;
      for (int r = 0; r < Rows; r++) begin
        results[r] <= '0;
      end
    end else begin
      // start leaves here one cycle after the accepted write
      startReg <= startWrite;
      if (wrOk && isInput) begin
        inVecReg <= PWDATA[Inputs-1:0];
      end
      if (startWrite) begin
        doneFlag <= 1'b0;
      end else if (done) begin
        doneFlag <= 1'b1;
      end
      // sums are final while done is high
      if (done) begin
        for (int r = 0; r < Rows; r++) begin
          results[r] <= sums[r*SumW +: SumW];
        end
      end
    end
  end

  // read mux, unused bits stay zero
  always_comb begin
    PRDATA = '0;
    if (isStatus) begin
      PRDATA[1:0] = {doneFlag, busy};
    end else if (isInput) begin
      PRDATA[Inputs-1:0] = inVecReg;
    end else if (isResult) begin
      PRDATA[SumW-1:0] = results[resIdx];
    end
  end

endmodule

// ==== logic/layerPkg.sv ====
package layerPkg;

  // widest input vector the datapath is sized for
  localparam int MaxInputs = 8;

  localparam int IdxW = $clog2(MaxInputs);
  // one extra bit so a count can reach MaxInputs itself
  localparam int CountW = IdxW + 1;
  // doubled count plus the normalising offset
  localparam int SumW = CountW + 2;

  // bit position within the input vector
  typedef logic [IdxW-1:0] idx_t;

  // number of sign matches seen by one row
  typedef logic [CountW-1:0] count_t;

  // corrected row result as seen by software
  typedef logic [SumW-1:0] sum_t;

endpackage

// ==== logic/rowAccum.sv ====
`timescale 1ns/1ns

module rowAccum #(
  parameter int Inputs = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic clear,
  input  logic valid,
  input  logic scanBit,
  input  layerPkg::idx_t idx,
  input  logic [Inputs-1:0] colMask,
  input  logic [Inputs-1:0] signMask,
  output layerPkg::count_t count
);

  logic hit;

  // serial xnor popcount over the columns this row uses
  assign hit = valid && colMask[idx] && (scanBit == signMask[idx]);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (hit) begin
      count <= count + 1'b1;
    end
  end

endmodule

// ==== logic/scanSequencer.sv ====
`timescale 1ns/1ns

module scanSequencer #(
  parameter int Inputs = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic [Inputs-1:0] inVec,
  output logic scanBit,
  output layerPkg::idx_t idx,
  output logic valid,
  output logic clear,
  output logic busy,
  output logic done
);

  typedef enum logic [1:0] {
    Idle,
    Scan,
    Finish
  } state_t;

  state_t state;
  logic [Inputs-1:0] shiftReg;
  layerPkg::idx_t idxReg;
  logic lastBit;

  assign lastBit = (idxReg == layerPkg::idx_t'(Inputs - 1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= Idle;
      idxReg <= '0;
    end else if (start) begin
      state <= Scan;
      idxReg <= '0;
    end else begin
      case (state)
        Scan: begin
          idxReg <= idxReg + 1'b1;
          if (lastBit) begin
            state <= Finish;
          end
        end
        Finish: state <= Idle;
        default: state <= Idle;
      endcase
    end
  end

  // vector snapshot shifted out lsb first
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shiftReg <= '0;
    end else if (start) begin
      shiftReg <= inVec;
    end else if (state == Scan) begin
      shiftReg <= shiftReg >> 1;
    end
  end

  assign scanBit = shiftReg[0];
  assign idx = idxReg;
  assign valid = (state == Scan);
  // accumulators restart together with the snapshot
  assign clear = start;
  assign busy = (state != Idle);
  assign done = (state == Finish);

endmodule

// ==== logic/sparseXnorArray.sv ====
`timescale 1ns/1ns

module sparseXnorArray #(
  parameter int Inputs = 8,
  parameter int Rows = 1,
  // compressed-row weights, 8 bits per entry
  parameter logic [(Rows+1)*8-1:0] RowStart = 16'h0100,
  parameter logic [Rows*8-1:0] RowLen = 8'h01,
  parameter ColIdx = 8'h00,
  parameter Signs = 1'b1,
  parameter int MaxLen = 1
) (
  input  logic clk,
  input  logic rst,
  input  logic clear,
  input  logic valid,
  input  logic scanBit,
  input  layerPkg::idx_t idx,
  output logic [Rows*$bits(layerPkg::sum_t)-1:0] sums
);

  localparam int SumW = $bits(layerPkg::sum_t);

  // flatten one row of the compressed form into a per-column mask
  function automatic logic [Inputs-1:0] rowMask(input int row, input logic signOnly);
    logic [Inputs-1:0] mask;
    int first;
    int len;
    int col;
    mask = '0;
    first = RowStart[row*8 +: 8];
    len = RowLen[row*8 +: 8];
    for (int k = 0; k < len; k++) begin
      col = ColIdx[(first+k)*8 +: 8];
      if (!signOnly || Signs[first+k]) begin
        mask[col] = 1'b1;
      end
    end
    return mask;
  endfunction

  for (genvar r = 0; r < Rows; r++) begin : gRow
    localparam int Len = RowLen[r*8 +: 8];
    if (Len != 0) begin : gUsed
      localparam logic [Inputs-1:0] ColMask = rowMask(r, 1'b0);
      localparam logic [Inputs-1:0] SignMask = rowMask(r, 1'b1);
      layerPkg::count_t rowCount;

      rowAccum #(
        .Inputs(Inputs)
      ) i_rowAccum (
        .clk(clk),
        .rst(rst),
        .clear(clear),
        .valid(valid),
        .scanBit(scanBit),
        .idx(idx),
        .colMask(ColMask),
        .signMask(SignMask),
        .count(rowCount)
      );

      // matches minus mismatches, shifted by the normalising length
      assign sums[r*SumW +: SumW] = layerPkg::sum_t'(2 * int'(rowCount) + MaxLen - Len);
    end else begin : gEmpty
      assign sums[r*SumW +: SumW] = layerPkg::sum_t'(MaxLen);
    end
  end

endmodule

// ==== logic/xnorLayerTop.sv ====
`timescale 1ns/1ns

module xnorLayerTop #(
  parameter int Inputs = 8,
  parameter int Rows = 1,
  parameter logic [(Rows+1)*8-1:0] RowStart = 16'h0100,
  parameter logic [Rows*8-1:0] RowLen = 8'h01,
  parameter ColIdx = 8'h00,
  parameter Signs = 1'b1,
  parameter int MaxLen = 1
) (
  input  logic clk,
  input  logic rst,
  input  logic PSEL,
  input  logic PENABLE,
  input  logic PWRITE,
  input  apbPkg::addr_t PADDR,
  input  apbPkg::data_t PWDATA,
  output apbPkg::data_t PRDATA,
  output logic PREADY,
  output logic PSLVERR
);

  logic start;
  logic [Inputs-1:0] inVec;
  logic busy;
  logic done;
  logic scanBit;
  layerPkg::idx_t idx;
  logic valid;
  logic clear;
  logic [Rows*$bits(layerPkg::sum_t)-1:0] sums;

  apbRegs #(
    .Inputs(Inputs),
    .Rows(Rows)
  ) i_apbRegs (
    .clk(clk),
    .rst(rst),
    .PSEL(PSEL),
    .PENABLE(PENABLE),
    .PWRITE(PWRITE),
    .PADDR(PADDR),
    .PWDATA(PWDATA),
    .PRDATA(PRDATA),
    .PREADY(PREADY),
    .PSLVERR(PSLVERR),
    .start(start),
    .inVec(inVec),
    .busy(busy),
    .done(done),
    .sums(sums)
  );

  // one counter drives every row in lockstep
  scanSequencer #(
    .Inputs(Inputs)
  ) i_scanSequencer (
    .clk(clk),
    .rst(rst),
    .start(start),
    .inVec(inVec),
    .scanBit(scanBit),
    .idx(idx),
    .valid(valid),
    .clear(clear),
    .busy(busy),
    .done(done)
  );

  sparseXnorArray #(
    .Inputs(Inputs),
    .Rows(Rows),
    .RowStart(RowStart),
    .RowLen(RowLen),
    .ColIdx(ColIdx),
    .Signs(Signs),
    .MaxLen(MaxLen)
  ) i_sparseXnorArray (
    .clk(clk),
    .rst(rst),
    .clear(clear),
    .valid(valid),
    .scanBit(scanBit),
    .idx(idx),
    .sums(sums)
  );

endmodule
